// File: hdl/mdc_pkg.sv
/*
 * matrix minor calculator shared definitions
 * codeword, element and determinant widths plus matrix size
 */

`default_nettype none

package mdc_pkg;

    // ==================================================================
    // widths
    // ==================================================================
    parameter int code_w = 15;  // hamming(15,11) codeword
    parameter int elem_w = 11;  // decoded data bits
    parameter int det_w  = 23;  // a*d - b*c worst case plus sign
    parameter int mat_n  = 4;   // rows and columns per matrix

    // ==================================================================
    // payload types
    // ==================================================================
    // codeword bit layout
    //   bit 14 is hamming position 1, bit 0 is position 15
    //   parity at positions 1, 2, 4, 8
    //   data msb first at positions 3, 5, 6, 7, 9..15
    typedef logic [code_w-1:0] code_t;

    // two's complement element taken from the 11 data bits
    typedef logic signed [elem_w-1:0] elem_t;

    // one 2x2 minor, sign extended
    typedef logic signed [det_w-1:0] det_t;

endpackage

`default_nettype wire

// File: hdl/element_decoder.sv
/*
 * element decoder
 * single bit hamming correction and data extraction, one codeword per cycle
 */

`timescale 1ns/100ps
`default_nettype none

module element_decoder (
    input  wire logic           clk,
    input  wire logic           rst_n,
    input  wire logic           code_valid,
    input  wire mdc_pkg::code_t code,
    output logic                elem_valid,
    output mdc_pkg::elem_t      elem
);

    localparam int syn_w = $clog2(mdc_pkg::code_w + 1);  // 4 bits for 15 positions

    logic [syn_w-1:0] syndrome;  // position of flipped bit, 0 when clean
    mdc_pkg::code_t   fixed;     // corrected codeword
    mdc_pkg::elem_t   data;      // extracted data bits

    // ==================================================================
    // syndrome and correction
    // ==================================================================
    always_comb begin
        syndrome = '0;
        for (int p = 1; p <= mdc_pkg::code_w; p++) begin
            if (code[mdc_pkg::code_w - p]) begin  // position p sits at bit 15-p
                syndrome = syndrome ^ syn_w'(p);
            end
        end
    end

    always_comb begin
        fixed = code;
        if (syndrome != '0) begin
            // flip the bit the syndrome points at
            fixed[mdc_pkg::code_w - int'(syndrome)] = ~code[mdc_pkg::code_w - int'(syndrome)];
        end
    end

    // data at positions 3, 5..7, 9..15
    assign data = {fixed[12], fixed[10:8], fixed[6:0]};

    // ==================================================================
    // output stage
    // ==================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            elem_valid <= 1'b0;
        end else begin
            elem_valid <= code_valid;  // fixed 1 cycle latency
        end
    end

    always_ff @(posedge clk) begin
        if (code_valid) begin
            elem <= data;
        end
    end

endmodule

`default_nettype wire

// File: hdl/credit_fifo.sv
/*
 * credit fifo, generic payload
 * sends head item against downstream credits, returns one credit upstream per send
 */

`timescale 1ns/100ps
`default_nettype none

module credit_fifo #(
    parameter int  depth        = 4,
    parameter int  init_credits = 0,
    parameter type payload_t    = logic [7:0]
) (
    input  wire logic     clk,
    input  wire logic     rst_n,
    input  wire logic     push_valid,
    input  wire payload_t push_data,
    output logic          push_credit,
    output logic          pop_valid,
    output payload_t      pop_data,
    input  wire logic     pop_credit
);

    localparam int ptr_w  = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w  = $clog2(depth + 1);
    localparam int cred_w = 16;  // headroom for credits banked by the sink

    localparam logic [ptr_w-1:0] last_ptr = ptr_w'(depth - 1);

    payload_t          mem [depth];  // circular store
    logic [ptr_w-1:0]  wr_ptr;
    logic [ptr_w-1:0]  rd_ptr;
    logic [cnt_w-1:0]  count;        // items held
    logic [cred_w-1:0] credits;      // downstream slots we may still fill
    logic              send;

    // ==================================================================
    // send decision
    // ==================================================================
    // head goes out once stored and the receiver has room
    assign send        = (count != '0) && (credits != '0);
    assign pop_valid   = send;
    assign pop_data    = mem[rd_ptr];
    assign push_credit = send;  // slot freed on the same cycle

    // ==================================================================
    // store
    // ==================================================================
    always_ff @(posedge clk) begin
        if (push_valid) begin
            mem[wr_ptr] <= push_data;  // upstream never pushes when full
        end
    end

    // ==================================================================
    // pointers, fill level, credits
    // ==================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push_valid) begin
                wr_ptr <= (wr_ptr == last_ptr) ? '0 : wr_ptr + 1'b1;
            end
            if (send) begin
                rd_ptr <= (rd_ptr == last_ptr) ? '0 : rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else begin
            count <= count + cnt_w'(push_valid) - cnt_w'(send);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credits <= cred_w'(init_credits);  // receiver slot count
        end else begin
            // spend one per send, gain one per returned pulse
            credits <= credits + cred_w'(pop_credit) - cred_w'(send);
        end
    end

endmodule

`default_nettype wire

// File: hdl/minor_engine.sv
/*
 * minor engine
 * tracks element position and emits a*d - b*c for every 2x2 window
 */

`timescale 1ns/100ps
`default_nettype none

module minor_engine #(
    parameter int out_depth = 4
) (
    input  wire logic           clk,
    input  wire logic           rst_n,
    input  wire logic           elem_valid,
    input  wire mdc_pkg::elem_t elem,
    output logic                elem_credit,
    output logic                det_valid,
    output mdc_pkg::det_t       det,
    input  wire logic           det_credit
);

    localparam int idx_w  = $clog2(mdc_pkg::mat_n);
    localparam int cred_w = $clog2(out_depth + 1);

    localparam logic [idx_w-1:0] last_idx = idx_w'(mdc_pkg::mat_n - 1);

    logic              slot_valid;  // single input slot
    mdc_pkg::elem_t    slot_data;
    logic [idx_w-1:0]  row;
    logic [idx_w-1:0]  col;
    logic [idx_w-1:0]  col_m1;      // column to the left
    mdc_pkg::elem_t    prev_row [mdc_pkg::mat_n];
    mdc_pkg::elem_t    cur_row  [mdc_pkg::mat_n];
    logic [cred_w-1:0] res_cred;    // free result fifo slots
    logic              need_det;
    logic              consume;
    logic              reserve;     // consume that yields a result
    mdc_pkg::det_t     prod_ad;
    mdc_pkg::det_t     prod_bc;

    // ==================================================================
    // consume control
    // ==================================================================
    assign need_det    = (row != '0) && (col != '0);  // window closes here
    // stall only when a result is due and no room downstream
    assign consume     = slot_valid && (!need_det || (res_cred != '0));
    assign reserve     = consume && need_det;
    assign elem_credit = consume;  // hand the slot back
    assign col_m1      = col - 1'b1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot_valid <= 1'b0;
        end else if (elem_valid) begin
            slot_valid <= 1'b1;  // fifo only sends into a free slot
        end else if (consume) begin
            slot_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (elem_valid) begin
            slot_data <= elem;
        end
    end

    // row major position, wraps to the next matrix after 16
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            row <= '0;
            col <= '0;
        end else if (consume) begin
            if (col == last_idx) begin
                col <= '0;
                row <= (row == last_idx) ? '0 : row + 1'b1;
            end else begin
                col <= col + 1'b1;
            end
        end
    end

    // ==================================================================
    // row buffers
    // ==================================================================
    always_ff @(posedge clk) begin
        if (consume) begin
            cur_row[col] <= slot_data;
            if (col == last_idx) begin
                // finished row becomes the upper row of the next windows
                for (int i = 0; i < mdc_pkg::mat_n; i++) begin
                    prev_row[i] <= (i == mdc_pkg::mat_n - 1) ? slot_data : cur_row[i];
                end
            end
        end
    end

    // ==================================================================
    // determinant
    // ==================================================================
    // signed operands widen to det_t before the multiply
    assign prod_ad = prev_row[col_m1] * slot_data;   // a*d
    assign prod_bc = prev_row[col] * cur_row[col_m1];  // b*c

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            det_valid <= 1'b0;
        end else begin
            det_valid <= reserve;  // 1 cycle after consume
        end
    end

    always_ff @(posedge clk) begin
        if (reserve) begin
            det <= prod_ad - prod_bc;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res_cred <= cred_w'(out_depth);
        end else begin
            res_cred <= res_cred + cred_w'(det_credit) - cred_w'(reserve);
        end
    end

endmodule

`default_nettype wire

// File: hdl/mdc_top.sv
/*
 * matrix minor calculator top
 * decoder, element fifo, minor engine and result fifo with credit flow control
 */

`timescale 1ns/100ps
`default_nettype none

module mdc_top #(
    parameter int in_depth  = 4,  // element fifo slots, source credits
    parameter int out_depth = 4   // result fifo slots
) (
    input  wire logic           clk,
    input  wire logic           rst_n,
    input  wire logic           in_valid,
    input  wire mdc_pkg::code_t in_data,
    output logic                in_credit,
    output logic                out_valid,
    output mdc_pkg::det_t       out_data,
    input  wire logic           out_credit
);

    logic           dec_valid;    // decoder to element fifo
    mdc_pkg::elem_t dec_elem;
    logic           eng_valid;    // element fifo to engine
    mdc_pkg::elem_t eng_elem;
    logic           eng_credit;   // engine slot freed
    logic           det_valid;    // engine to result fifo
    mdc_pkg::det_t  det;
    logic           det_credit;   // result fifo slot freed

    // ==================================================================
    // input side
    // ==================================================================
    element_decoder dec_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .code_valid (in_valid),
        .code       (in_data),
        .elem_valid (dec_valid),
        .elem       (dec_elem)
    );

    // one credit toward the engine's single slot
    credit_fifo #(
        .depth        (in_depth),
        .init_credits (1),
        .payload_t    (mdc_pkg::elem_t)
    ) elem_fifo_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .push_valid  (dec_valid),
        .push_data   (dec_elem),
        .push_credit (in_credit),  // back to the source
        .pop_valid   (eng_valid),
        .pop_data    (eng_elem),
        .pop_credit  (eng_credit)
    );

    // ==================================================================
    // compute and output side
    // ==================================================================
    minor_engine #(
        .out_depth (out_depth)
    ) eng_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .elem_valid  (eng_valid),
        .elem        (eng_elem),
        .elem_credit (eng_credit),
        .det_valid   (det_valid),
        .det         (det),
        .det_credit  (det_credit)
    );

    // sink grants every result, nothing banked at reset
    credit_fifo #(
        .depth        (out_depth),
        .init_credits (0),
        .payload_t    (mdc_pkg::det_t)
    ) det_fifo_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .push_valid  (det_valid),
        .push_data   (det),
        .push_credit (det_credit),
        .pop_valid   (out_valid),
        .pop_data    (out_data),
        .pop_credit  (out_credit)
    );

endmodule

`default_nettype wire

// File: dv/mdc_tb_model.svh
/*
 * testbench model for the minor calculator
 * hamming(15,11) encoder, single bit flip and reference 2x2 minor
 */

`ifndef mdc_tb_model_svh
`define mdc_tb_model_svh

    // codeword position p sits at bit 15-p, parity at 1, 2, 4, 8
    function automatic mdc_pkg::code_t hamming_encode(input mdc_pkg::elem_t data);
        mdc_pkg::code_t cw;
        logic [3:0]     syn;
        int             k;
        cw  = '0;
        syn = '0;
        k   = mdc_pkg::elem_w - 1;  // data msb goes first
        for (int p = 1; p <= mdc_pkg::code_w; p++) begin
            if ((p & (p - 1)) != 0) begin  // skip powers of two
                cw[mdc_pkg::code_w - p] = data[k];
                k--;
            end
        end
        // syndrome of the data bits alone
        for (int p = 1; p <= mdc_pkg::code_w; p++) begin
            if (cw[mdc_pkg::code_w - p]) begin
                syn = syn ^ 4'(p);
            end
        end
        // parity bit at 2^b cancels syndrome bit b
        for (int b = 0; b < 4; b++) begin
            if (syn[b]) begin
                cw[mdc_pkg::code_w - (1 << b)] = 1'b1;
            end
        end
        return cw;
    endfunction

    // invert hamming position pos (1..15)
    function automatic mdc_pkg::code_t flip_bit(input mdc_pkg::code_t cw, input int pos);
        mdc_pkg::code_t res;
        res = cw;
        res[mdc_pkg::code_w - pos] = ~cw[mdc_pkg::code_w - pos];
        return res;
    endfunction

    // a*d - b*c in full int precision, then cut to det width
    function automatic mdc_pkg::det_t minor_det(input mdc_pkg::elem_t a, input mdc_pkg::elem_t b,
                                                input mdc_pkg::elem_t c, input mdc_pkg::elem_t d);
        int ad;
        int bc;
        ad = int'(a) * int'(d);
        bc = int'(b) * int'(c);
        return mdc_pkg::det_t'(ad - bc);
    endfunction

`endif

// File: dv/mdc_tb.sv
/*
 * minor calculator testbench
 * credit based source and sink, expected minor queue, checks by immediate assertions
 */

`timescale 1ns/100ps
`default_nettype none

module mdc_tb;

    `include "mdc_tb_model.svh"

    localparam int in_depth    = 4;
    localparam int out_depth   = 4;
    localparam int sink_slots  = 2;    // results the sink holds before returning credit
    localparam int n_mats      = 11;
    localparam int hold_len    = 150;  // cycles with out_credit withheld
    localparam int cycle_limit = n_mats * 16 * 8 + hold_len + 200;

    logic           clk;
    logic           rst_n;
    logic           in_valid;
    mdc_pkg::code_t in_data;
    logic           in_credit;
    logic           out_valid;
    mdc_pkg::det_t  out_data;
    logic           out_credit;

    mdc_pkg::elem_t mat [16];   // clean matrix, row major
    mdc_pkg::det_t  exp_q [$];  // minors still to come
    logic           hold;       // sink withholds credits
    int sent_cnt;               // elements sent by the source
    int credit_cnt;             // in_credit pulses seen
    int out_given;              // out_credit pulses issued
    int out_beats;              // out_valid beats seen
    int errors;
    int checks;
    int cycles;

    mdc_top #(
        .in_depth  (in_depth),
        .out_depth (out_depth)
    ) dut_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_data    (in_data),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .out_credit (out_credit)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // 20 ns period
    end

    // ======================================================================
    // stimulus helpers
    // ======================================================================
    // window order: row pairs top down, column pairs left to right
    task automatic queue_expected();
        for (int r = 1; r < mdc_pkg::mat_n; r++) begin
            for (int c = 1; c < mdc_pkg::mat_n; c++) begin
                exp_q.push_back(minor_det(mat[(r - 1) * 4 + c - 1], mat[(r - 1) * 4 + c],
                                          mat[r * 4 + c - 1], mat[r * 4 + c]));
            end
        end
    endtask

    // one beat, only against a held credit
    task automatic send_code(input mdc_pkg::code_t code);
        @(posedge clk);
        while (in_depth + credit_cnt - sent_cnt <= 0) begin
            in_valid <= 1'b0;  // out of credits, idle
            @(posedge clk);
        end
        in_valid <= 1'b1;
        in_data  <= code;
        sent_cnt <= sent_cnt + 1;
    endtask

    task automatic send_matrix(input bit flip);
        mdc_pkg::code_t code;
        queue_expected();
        for (int i = 0; i < 16; i++) begin
            code = hamming_encode(mat[i]);
            if (flip) begin
                code = flip_bit(code, $urandom_range(1, 15));  // any single position
            end
            send_code(code);
        end
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    task automatic fill_random();
        for (int i = 0; i < 16; i++) begin
            mat[i] = mdc_pkg::elem_t'($urandom());
        end
    endtask

    // only -1024 and 1023, worst case products
    task automatic fill_extreme();
        for (int i = 0; i < 16; i++) begin
            mat[i] = ($urandom_range(0, 1) == 0) ? mdc_pkg::elem_t'(-1024)
                                                 : mdc_pkg::elem_t'(1023);
        end
    endtask

    task automatic withhold_credits();
        hold <= 1'b1;
        repeat (hold_len) @(posedge clk);
        checks++;
        // backlog must have reached the source by now
        assert (sent_cnt - credit_cnt == in_depth) else begin
            $display("source still held credits after %0d cycles without out_credit", hold_len);
            errors++;
        end
        hold <= 1'b0;
    endtask

    // ======================================================================
    // sink, scoreboard and watchdog
    // ======================================================================
    always @(posedge clk) begin
        logic give;
        give = rst_n && !hold && (out_given - out_beats < sink_slots)
               && ($urandom_range(0, 3) != 0);  // sometimes late
        out_credit <= give;
        if (give) begin
            out_given <= out_given + 1;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (rst_n) begin
            checks++;
            // every in_credit pulse frees the slot of an element already sent
            assert (!in_credit || (credit_cnt < sent_cnt)) else begin
                $display("in_credit pulse with no element outstanding: %0d sent, %0d pulses",
                         sent_cnt, credit_cnt);
                errors++;
            end
            if (in_credit) begin
                credit_cnt <= credit_cnt + 1;
            end
            if (out_valid) begin
                checks++;
                assert (out_beats < out_given) else begin
                    $display("out_valid beat %0d without a matching out_credit", out_beats + 1);
                    errors++;
                end
                assert (exp_q.size() != 0) else begin
                    $display("result arrived with no result expected");
                    errors++;
                end
                if (exp_q.size() != 0) begin
                    assert (out_data == exp_q[0]) else begin
                        $display("** Error out_data: got %h expected %h", out_data, exp_q[0]);
                        errors++;
                    end
                    exp_q.pop_front();
                end
                out_beats <= out_beats + 1;
            end
        end
        if (cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, %0d results missing", cycles, exp_q.size());
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // ======================================================================
    // test sequence
    // ======================================================================
    initial begin
        void'($urandom(32'h537bcc30));
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        in_data    = '0;
        out_credit = 1'b0;
        hold       = 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        // quiet outputs before any stimulus
        repeat (4) begin
            @(posedge clk);
            checks++;
            assert (!out_valid && !in_credit) else begin
                $display("out_valid or in_credit active before stimulus");
                errors++;
            end
        end

        repeat (3) begin  // clean codewords
            fill_random();
            send_matrix(1'b0);
        end
        repeat (3) begin  // one flipped bit per codeword
            fill_random();
            send_matrix(1'b1);
        end
        repeat (2) begin
            fill_extreme();
            send_matrix(1'b1);
        end
        fork  // back pressure all the way to the source
            repeat (3) begin
                fill_random();
                send_matrix(1'b1);
            end
            withhold_credits();
        join

        while (exp_q.size() != 0) @(posedge clk);
        repeat (4) @(posedge clk);  // let late credit pulses land
        checks += 2;
        assert (credit_cnt == sent_cnt) else begin
            $display("%0d in_credit pulses for %0d elements sent", credit_cnt, sent_cnt);
            errors++;
        end
        assert (out_beats == n_mats * 9) else begin
            $display("%0d results seen, %0d expected", out_beats, n_mats * 9);
            errors++;
        end

        $display("checks %0d, errors %0d, results %0d, elements %0d",
                 checks, errors, out_beats, sent_cnt);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
+incdir+dv
hdl/mdc_pkg.sv
hdl/element_decoder.sv
hdl/credit_fifo.sv
hdl/minor_engine.sv
hdl/mdc_top.sv
dv/mdc_tb.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := mdc_tb
FILELIST  := files.f
OBJ_DIR   := obj_dir
LOG       := sim.log

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST)) $(wildcard dv/*.svh)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q '^RESULT: PASS$$' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
